/* exec_defines.svh */
// data width, tag width and unit depth macros for the execution cluster
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width
`define EXEC_XLEN 32

// destination tag carried with each operation
`define EXEC_TAG_W 6

// multiplier pipeline depth
`define EXEC_MUL_STAGES 3

// one quotient bit per divider step
`define EXEC_DIV_STEPS 32

`endif

/* exec_pkg.sv */
// operation and unit-select enums shared by the execution cluster
package exec_pkg;

    // operations understood by the back end
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_mul  = 4'd10,
        op_mulh = 4'd11,
        op_div  = 4'd12,
        op_divu = 4'd13,
        op_rem  = 4'd14,
        op_remu = 4'd15
    } exec_op_e;

    // execution unit targets
    typedef enum logic [1:0] {
        unit_alu = 2'd0,
        unit_mul = 2'd1,
        unit_div = 2'd2
    } exec_unit_e;

endpackage

/* issue_register.sv */
// issue-to-execute register holding one operation and routing it to a unit
`include "exec_defines.svh"

module issue_register
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  exec_op_e               issue_op,
    input  logic [`EXEC_TAG_W-1:0] issue_tag,
    input  logic [`EXEC_XLEN-1:0]  issue_pc,
    input  logic [`EXEC_XLEN-1:0]  issue_src1,
    input  logic [`EXEC_XLEN-1:0]  issue_src2,
    output logic                   alu_start,
    output logic                   mul_start,
    output logic                   div_start,
    input  logic                   alu_ready,
    input  logic                   mul_ready,
    input  logic                   div_ready,
    output exec_op_e               ex_op,
    output logic [`EXEC_TAG_W-1:0] ex_tag,
    output logic [`EXEC_XLEN-1:0]  ex_pc,
    output logic [`EXEC_XLEN-1:0]  ex_src1,
    output logic [`EXEC_XLEN-1:0]  ex_src2
);
    logic       occupied;
    logic       unit_ready;
    logic       taken;
    logic       load;
    exec_unit_e unit_sel;

    always_comb begin
        case (ex_op)
            op_mul, op_mulh:                  unit_sel = unit_mul;
            op_div, op_divu, op_rem, op_remu: unit_sel = unit_div;
            default:                          unit_sel = unit_alu;
        endcase
    end

    always_comb begin
        case (unit_sel)
            unit_mul: unit_ready = mul_ready;
            unit_div: unit_ready = div_ready;
            default:  unit_ready = alu_ready;
        endcase
    end

    assign alu_start = occupied && (unit_sel == unit_alu);
    assign mul_start = occupied && (unit_sel == unit_mul);
    assign div_start = occupied && (unit_sel == unit_div);

    // refill when empty or when the held op leaves this cycle
    assign taken       = occupied && unit_ready;
    assign issue_ready = !occupied || taken;
    assign load        = issue_valid && issue_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupied <= 1'b0;
        end else if (flush) begin
            occupied <= 1'b0;
        end else if (load) begin
            occupied <= 1'b1;
        end else if (taken) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_op   <= issue_op;
            ex_tag  <= issue_tag;
            ex_pc   <= issue_pc;
            ex_src1 <= issue_src1;
            ex_src2 <= issue_src2;
        end
    end

endmodule

/* alu_unit.sv */
// single-cycle integer ALU with one registered result slot
`include "exec_defines.svh"

module alu_unit
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   start,
    output logic                   ready,
    input  exec_op_e               op,
    input  logic [`EXEC_TAG_W-1:0] tag,
    input  logic [`EXEC_XLEN-1:0]  pc,
    input  logic [`EXEC_XLEN-1:0]  src1,
    input  logic [`EXEC_XLEN-1:0]  src2,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] res_tag,
    output logic [`EXEC_XLEN-1:0]  res_value,
    output logic [`EXEC_XLEN-1:0]  res_pc,
    input  logic                   grant
);
    logic                  slot_valid;
    logic                  accept;
    logic [4:0]            shamt;
    logic [`EXEC_XLEN-1:0] result;

    assign shamt  = src2[4:0];
    assign ready  = !slot_valid || grant;
    assign accept = start && ready && !flush;
    assign done   = slot_valid;

    always_comb begin
        case (op)
            op_add:  result = src1 + src2;
            op_sub:  result = src1 - src2;
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_xor:  result = src1 ^ src2;
            op_sll:  result = src1 << shamt;
            op_srl:  result = src1 >> shamt;
            op_sra:  result = $signed(src1) >>> shamt;
            op_slt:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            op_sltu: result = {{(`EXEC_XLEN-1){1'b0}}, src1 < src2};
            default: result = '0;
        endcase
    end

    // slot empties on grant unless a new result replaces it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (flush) begin
            slot_valid <= 1'b0;
        end else if (accept) begin
            slot_valid <= 1'b1;
        end else if (grant) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_tag   <= tag;
            res_value <= result;
            res_pc    <= pc;
        end
    end

endmodule

/* mul_unit.sv */
// three-stage signed multiplier returning the low or high product word
`include "exec_defines.svh"

module mul_unit
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   start,
    output logic                   ready,
    input  exec_op_e               op,
    input  logic [`EXEC_TAG_W-1:0] tag,
    input  logic [`EXEC_XLEN-1:0]  pc,
    input  logic [`EXEC_XLEN-1:0]  src1,
    input  logic [`EXEC_XLEN-1:0]  src2,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] res_tag,
    output logic [`EXEC_XLEN-1:0]  res_value,
    output logic [`EXEC_XLEN-1:0]  res_pc,
    input  logic                   grant
);
    localparam int STAGES = `EXEC_MUL_STAGES;
    localparam int LAST   = STAGES - 1;
    localparam int XLEN   = `EXEC_XLEN;

    logic [STAGES-1:0]       stage_valid;
    logic [`EXEC_TAG_W-1:0]  stage_tag [STAGES];
    logic [XLEN-1:0]         stage_pc  [STAGES];
    logic                    advance;
    logic                    accept;
    logic                    s0_hi;
    logic                    s1_hi;
    logic signed [XLEN-1:0]  s0_a;
    logic signed [XLEN-1:0]  s0_b;
    logic signed [2*XLEN-1:0] s1_prod;
    logic [XLEN-1:0]         s2_res;

    // whole pipe stalls behind an ungranted result
    assign advance = !stage_valid[LAST] || grant;
    assign ready   = advance;
    assign accept  = start && advance && !flush;

    assign done      = stage_valid[LAST];
    assign res_tag   = stage_tag[LAST];
    assign res_pc    = stage_pc[LAST];
    assign res_value = s2_res;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (flush) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[STAGES-2:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_tag[0] <= tag;
            stage_pc[0]  <= pc;
            for (int i = 1; i < STAGES; i++) begin
                stage_tag[i] <= stage_tag[i-1];
                stage_pc[i]  <= stage_pc[i-1];
            end
            // operand capture, product, word select
            s0_a    <= src1;
            s0_b    <= src2;
            s0_hi   <= (op == op_mulh);
            s1_prod <= s0_a * s0_b;
            s1_hi   <= s0_hi;
            s2_res  <= s1_hi ? s1_prod[2*XLEN-1:XLEN] : s1_prod[XLEN-1:0];
        end
    end

endmodule

/* div_unit.sv */
// iterative restoring divider for signed and unsigned quotient and remainder
`include "exec_defines.svh"

module div_unit
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   start,
    output logic                   ready,
    input  exec_op_e               op,
    input  logic [`EXEC_TAG_W-1:0] tag,
    input  logic [`EXEC_XLEN-1:0]  pc,
    input  logic [`EXEC_XLEN-1:0]  src1,
    input  logic [`EXEC_XLEN-1:0]  src2,
    output logic                   done,
    output logic [`EXEC_TAG_W-1:0] res_tag,
    output logic [`EXEC_XLEN-1:0]  res_value,
    output logic [`EXEC_XLEN-1:0]  res_pc,
    input  logic                   grant
);
    localparam int XLEN  = `EXEC_XLEN;
    localparam int STEPS = `EXEC_DIV_STEPS;
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;

    div_state_e       state;
    logic [CNT_W-1:0] count;
    logic             accept;
    logic             last_step;
    logic             op_signed;
    logic             neg_q;
    logic             neg_r;
    logic             by_zero;
    logic             want_rem;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [XLEN-1:0]  dividend;
    logic [XLEN-1:0]  divisor;
    logic [XLEN-1:0]  quo;
    logic [XLEN-1:0]  rem;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic [XLEN-1:0]  quo_next;
    logic [XLEN-1:0]  rem_next;
    logic [XLEN-1:0]  quo_fix;
    logic [XLEN-1:0]  rem_fix;

    assign op_signed = (op == op_div) || (op == op_rem);
    assign a_mag     = (op_signed && src1[XLEN-1]) ? -src1 : src1;
    assign b_mag     = (op_signed && src2[XLEN-1]) ? -src2 : src2;

    assign ready     = (state == div_idle) || (state == div_done && grant);
    assign accept    = start && ready && !flush;
    assign done      = (state == div_done);
    assign last_step = (count == CNT_W'(STEPS - 1));

    // one restoring step
    assign shifted  = {rem, quo[XLEN-1]};
    assign diff     = shifted - {1'b0, divisor};
    assign rem_next = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
    assign quo_next = {quo[XLEN-2:0], !diff[XLEN]};

    // most-negative / -1 already yields the dividend and a zero remainder
    assign quo_fix = by_zero ? '1 : (neg_q ? -quo_next : quo_next);
    assign rem_fix = by_zero ? dividend : (neg_r ? -rem_next : rem_next);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= div_idle;
            count <= '0;
        end else if (flush) begin
            state <= div_idle;
        end else if (accept) begin
            state <= div_run;
            count <= '0;
        end else if (state == div_run) begin
            count <= count + 1'b1;
            if (last_step) begin
                state <= div_done;
            end
        end else if (state == div_done && grant) begin
            state <= div_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dividend <= src1;
            divisor  <= b_mag;
            quo      <= a_mag;
            rem      <= '0;
            by_zero  <= (src2 == '0);
            neg_q    <= op_signed && (src1[XLEN-1] ^ src2[XLEN-1]);
            neg_r    <= op_signed && src1[XLEN-1];
            want_rem <= (op == op_rem) || (op == op_remu);
            res_tag  <= tag;
            res_pc   <= pc;
        end else if (state == div_run) begin
            quo <= quo_next;
            rem <= rem_next;
            if (last_step) begin
                res_value <= want_rem ? rem_fix : quo_fix;
            end
        end
    end

endmodule

/* result_arbiter.sv */
// fixed-priority completion bus arbiter, divider first, then multiplier, then ALU
`include "exec_defines.svh"

module result_arbiter
    import exec_pkg::*;
(
    input  logic                   flush,
    input  logic                   cdb_ready,
    input  logic                   alu_done,
    input  logic [`EXEC_TAG_W-1:0] alu_tag,
    input  logic [`EXEC_XLEN-1:0]  alu_value,
    input  logic [`EXEC_XLEN-1:0]  alu_pc,
    input  logic                   mul_done,
    input  logic [`EXEC_TAG_W-1:0] mul_tag,
    input  logic [`EXEC_XLEN-1:0]  mul_value,
    input  logic [`EXEC_XLEN-1:0]  mul_pc,
    input  logic                   div_done,
    input  logic [`EXEC_TAG_W-1:0] div_tag,
    input  logic [`EXEC_XLEN-1:0]  div_value,
    input  logic [`EXEC_XLEN-1:0]  div_pc,
    output logic                   alu_grant,
    output logic                   mul_grant,
    output logic                   div_grant,
    output logic                   cdb_valid,
    output logic [`EXEC_TAG_W-1:0] cdb_tag,
    output logic [`EXEC_XLEN-1:0]  cdb_value,
    output logic [`EXEC_XLEN-1:0]  cdb_pc
);
    logic       grant_en;
    exec_unit_e sel;

    assign grant_en = cdb_ready && !flush;

    always_comb begin
        if (div_done) begin
            sel = unit_div;
        end else if (mul_done) begin
            sel = unit_mul;
        end else begin
            sel = unit_alu;
        end
    end

    // nothing offered while a flush is in progress
    assign cdb_valid = !flush && (div_done || mul_done || alu_done);

    assign div_grant = grant_en && div_done;
    assign mul_grant = grant_en && mul_done && (sel == unit_mul);
    assign alu_grant = grant_en && alu_done && (sel == unit_alu);

    always_comb begin
        case (sel)
            unit_div: begin
                cdb_tag   = div_tag;
                cdb_value = div_value;
                cdb_pc    = div_pc;
            end
            unit_mul: begin
                cdb_tag   = mul_tag;
                cdb_value = mul_value;
                cdb_pc    = mul_pc;
            end
            default: begin
                cdb_tag   = alu_tag;
                cdb_value = alu_value;
                cdb_pc    = alu_pc;
            end
        endcase
    end

endmodule

/* exec_cluster.sv */
// execution cluster top with issue register, ALU, multiplier, divider and arbiter
`include "exec_defines.svh"

module exec_cluster
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  exec_op_e               issue_op,
    input  logic [`EXEC_TAG_W-1:0] issue_tag,
    input  logic [`EXEC_XLEN-1:0]  issue_pc,
    input  logic [`EXEC_XLEN-1:0]  issue_src1,
    input  logic [`EXEC_XLEN-1:0]  issue_src2,
    input  logic                   cdb_ready,
    output logic                   cdb_valid,
    output logic [`EXEC_TAG_W-1:0] cdb_tag,
    output logic [`EXEC_XLEN-1:0]  cdb_value,
    output logic [`EXEC_XLEN-1:0]  cdb_pc
);
    logic                   alu_start, mul_start, div_start;
    logic                   alu_ready, mul_ready, div_ready;
    logic                   alu_done, mul_done, div_done;
    logic                   alu_grant, mul_grant, div_grant;
    exec_op_e               ex_op;
    logic [`EXEC_TAG_W-1:0] ex_tag, alu_tag, mul_tag, div_tag;
    logic [`EXEC_XLEN-1:0]  ex_pc, ex_src1, ex_src2;
    logic [`EXEC_XLEN-1:0]  alu_value, mul_value, div_value;
    logic [`EXEC_XLEN-1:0]  alu_pc, mul_pc, div_pc;

    issue_register u_issue (
        .clk(clk), .reset(reset), .flush(flush),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
        .issue_tag(issue_tag), .issue_pc(issue_pc),
        .issue_src1(issue_src1), .issue_src2(issue_src2),
        .alu_start(alu_start), .mul_start(mul_start), .div_start(div_start),
        .alu_ready(alu_ready), .mul_ready(mul_ready), .div_ready(div_ready),
        .ex_op(ex_op), .ex_tag(ex_tag), .ex_pc(ex_pc),
        .ex_src1(ex_src1), .ex_src2(ex_src2)
    );

    alu_unit u_alu (
        .clk(clk), .reset(reset), .flush(flush),
        .start(alu_start), .ready(alu_ready),
        .op(ex_op), .tag(ex_tag), .pc(ex_pc), .src1(ex_src1), .src2(ex_src2),
        .done(alu_done), .res_tag(alu_tag), .res_value(alu_value), .res_pc(alu_pc),
        .grant(alu_grant)
    );

    mul_unit u_mul (
        .clk(clk), .reset(reset), .flush(flush),
        .start(mul_start), .ready(mul_ready),
        .op(ex_op), .tag(ex_tag), .pc(ex_pc), .src1(ex_src1), .src2(ex_src2),
        .done(mul_done), .res_tag(mul_tag), .res_value(mul_value), .res_pc(mul_pc),
        .grant(mul_grant)
    );

    div_unit u_div (
        .clk(clk), .reset(reset), .flush(flush),
        .start(div_start), .ready(div_ready),
        .op(ex_op), .tag(ex_tag), .pc(ex_pc), .src1(ex_src1), .src2(ex_src2),
        .done(div_done), .res_tag(div_tag), .res_value(div_value), .res_pc(div_pc),
        .grant(div_grant)
    );

    result_arbiter u_arb (
        .flush(flush), .cdb_ready(cdb_ready),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_value(alu_value), .alu_pc(alu_pc),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_value(mul_value), .mul_pc(mul_pc),
        .div_done(div_done), .div_tag(div_tag), .div_value(div_value), .div_pc(div_pc),
        .alu_grant(alu_grant), .mul_grant(mul_grant), .div_grant(div_grant),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value), .cdb_pc(cdb_pc)
    );

endmodule

/* tb_exec_cluster.sv */
// testbench for the execution cluster with LFSR stimulus, result model and timeout
`include "exec_defines.svh"

module tb_exec_cluster
    import exec_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int XLEN       = `EXEC_XLEN;
    localparam int NTAGS      = 1 << `EXEC_TAG_W;
    localparam int TOTAL_OPS  = 60 + 40 + 20 + 50 + 52;
    localparam int MAX_CYCLES = TOTAL_OPS * 40 + 2000;
    localparam int DRAIN_MAX  = 200;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   flush;
    logic                   issue_valid;
    logic                   issue_ready;
    exec_op_e               issue_op;
    logic [`EXEC_TAG_W-1:0] issue_tag;
    logic [XLEN-1:0]        issue_pc;
    logic [XLEN-1:0]        issue_src1;
    logic [XLEN-1:0]        issue_src2;
    logic                   cdb_ready;
    logic                   cdb_valid;
    logic [`EXEC_TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]        cdb_value;
    logic [XLEN-1:0]        cdb_pc;

    // model state, indexed by tag
    logic            outstanding [NTAGS];
    logic [XLEN-1:0] exp_value [NTAGS];
    logic [XLEN-1:0] exp_pc [NTAGS];
    int              exp_unit [NTAGS];
    int              exp_seq [NTAGS];
    int              issue_seq [3];
    int              done_seq [3];
    int              pending = 0;

    logic [31:0]            lfsr = 32'h3b1;
    logic                   bp_mode = 1'b0;
    logic [`EXEC_TAG_W-1:0] tag_cnt;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_first_error = 0;
    int cycles = 0;

    exec_cluster u_exec_cluster (
        .clk(clk), .reset(reset), .flush(flush),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
        .issue_tag(issue_tag), .issue_pc(issue_pc),
        .issue_src1(issue_src1), .issue_src2(issue_src2),
        .cdb_ready(cdb_ready), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value), .cdb_pc(cdb_pc)
    );

    always #5 clk = !clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic int unit_of(input exec_op_e op);
        case (op)
            op_mul, op_mulh: return 1;
            op_div, op_divu, op_rem, op_remu: return 2;
            default: return 0;
        endcase
    endfunction

    // RISC-V M rules for zero divisor and signed overflow
    function automatic logic [XLEN-1:0] model_result(input exec_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] prod;
        logic [XLEN-1:0]          quo_s;
        logic [XLEN-1:0]          rem_s;
        logic [4:0]               sh;
        logic                     ovf;
        prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        sh   = b[4:0];
        ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        quo_s = '0;
        rem_s = '0;
        if (b != '0 && !ovf) begin
            quo_s = $signed(a) / $signed(b);
            rem_s = $signed(a) % $signed(b);
        end
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << sh;
            op_srl:  return a >> sh;
            op_sra:  return $signed(a) >>> sh;
            op_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            op_sltu: return (a < b) ? 1 : 0;
            op_mul:  return prod[XLEN-1:0];
            op_mulh: return prod[2*XLEN-1:XLEN];
            op_div:  return (b == '0) ? '1 : (ovf ? a : quo_s);
            op_divu: return (b == '0) ? '1 : a / b;
            op_rem:  return (b == '0) ? a : (ovf ? '0 : rem_s);
            op_remu: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic record_issue();
        int t;
        int u;
        t = issue_tag;
        u = unit_of(issue_op);
        if (outstanding[t]) begin
            error_count++;
            $display("tag %0d was issued again at %0t while still outstanding", t, $time);
        end
        outstanding[t] = 1'b1;
        exp_value[t]   = model_result(issue_op, issue_src1, issue_src2);
        exp_pc[t]      = issue_pc;
        exp_unit[t]    = u;
        exp_seq[t]     = issue_seq[u];
        issue_seq[u]++;
        pending++;
    endtask

    task automatic check_result();
        int t;
        int u;
        t = cdb_tag;
        check_count++;
        if (!outstanding[t]) begin
            error_count++;
            $display("result for tag %0d at %0t was not outstanding", t, $time);
        end else begin
            u = exp_unit[t];
            if (exp_seq[t] != done_seq[u]) begin
                error_count++;
                $display("tag %0d completed out of issue order at %0t", t, $time);
            end
            if (cdb_value != exp_value[t] || cdb_pc != exp_pc[t]) begin
                error_count++;
                $display("mismatch at %0t: tag %0d value %h pc %h, expected value %h pc %h",
                         $time, t, cdb_value, cdb_pc, exp_value[t], exp_pc[t]);
            end
            done_seq[u]    = exp_seq[t] + 1;
            outstanding[t] = 1'b0;
            pending--;
        end
    endtask

    // sampled mid-cycle, values hold until the next rising edge
    always @(negedge clk) begin : monitor
        int t;
        if (!reset) begin
            if (flush) begin
                if (cdb_valid) begin
                    error_count++;
                    $display("cdb_valid was high during the flush cycle at %0t", $time);
                end
                for (t = 0; t < NTAGS; t++) begin
                    outstanding[t] = 1'b0;
                end
                for (t = 0; t < 3; t++) begin
                    done_seq[t] = issue_seq[t];
                end
                pending = 0;
            end else begin
                if (cdb_valid && cdb_ready) begin
                    check_result();
                end
                if (issue_valid && issue_ready) begin
                    record_issue();
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
        cdb_ready = bp_mode ? (rand_bits(2) != 0) : 1'b1;
    endtask

    // kind 0 ALU, 1 multiply, 2 divide, 3 any
    function automatic exec_op_e pick_op(input int kind);
        logic [3:0] code;
        case (kind)
            0: code = 4'(rand_bits(4) % 10);
            1: code = 4'd10 + 4'(rand_bits(1));
            2: code = 4'd12 + 4'(rand_bits(2));
            default: code = 4'(rand_bits(4));
        endcase
        return exec_op_e'(code);
    endfunction

    task automatic present_op(input exec_op_e op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_tag   = tag_cnt;
        issue_pc    = rand_bits(30) << 2;
        issue_src1  = a;
        issue_src2  = b;
        tag_cnt     = tag_cnt + 1'b1;
    endtask

    task automatic send_op(input exec_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        logic taken;
        present_op(op, a, b);
        do begin
            @(negedge clk);
            taken = issue_ready;
            step();
        end while (!taken);
        issue_valid = 1'b0;
    endtask

    task automatic run_ops(input int count, input int kind, input int gap_bits);
        exec_op_e        op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              i;
        int              g;
        for (i = 0; i < count; i++) begin
            op = pick_op(kind);
            a  = rand_bits(32);
            b  = rand_bits(32);
            if (unit_of(op) == 2) begin
                case (rand_bits(2))
                    0: b = '0;
                    1: begin
                        a = {1'b1, {(XLEN-1){1'b0}}};
                        b = '1;
                    end
                    default: ;
                endcase
            end
            send_op(op, a, b);
            g = rand_bits(gap_bits);
            repeat (g) step();
        end
    endtask

    task automatic start_test(input logic bp);
        test_first_error = error_count;
        tag_cnt          = '0;
        bp_mode          = bp;
    endtask

    task automatic end_test(input string name);
        int w;
        int t;
        bp_mode = 1'b0;
        w = 0;
        while (pending != 0 && w < DRAIN_MAX) begin
            step();
            w++;
        end
        // a few idle cycles to catch repeated results
        repeat (5) step();
        for (t = 0; t < NTAGS; t++) begin
            if (outstanding[t]) begin
                error_count++;
                $display("tag %0d never completed in test %s", t, name);
                outstanding[t] = 1'b0;
            end
        end
        for (t = 0; t < 3; t++) begin
            done_seq[t] = issue_seq[t];
        end
        pending = 0;
        test_count++;
        $display("test %s finished with %0d errors", name, error_count - test_first_error);
    endtask

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = op_add;
        issue_tag   = '0;
        issue_pc    = '0;
        issue_src1  = '0;
        issue_src2  = '0;
        cdb_ready   = 1'b1;
        tag_cnt     = '0;
        for (int t = 0; t < NTAGS; t++) begin
            outstanding[t] = 1'b0;
        end
        for (int u = 0; u < 3; u++) begin
            issue_seq[u] = 0;
            done_seq[u]  = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test(1'b0);
        repeat (10) begin
            @(negedge clk);
            check_count++;
            if (cdb_valid || !issue_ready) begin
                error_count++;
                $display("wrong idle state after reset at %0t: cdb_valid %b issue_ready %b",
                         $time, cdb_valid, issue_ready);
            end
            step();
        end
        end_test("reset");

        start_test(1'b0);
        run_ops(60, 0, 1);
        end_test("alu");

        start_test(1'b0);
        run_ops(40, 1, 0);
        end_test("multiply");

        start_test(1'b0);
        run_ops(20, 2, 1);
        end_test("divide");

        start_test(1'b1);
        run_ops(50, 3, 2);
        end_test("mixed back-pressure");

        // flush lands with a divide in flight and another op offered
        start_test(1'b1);
        run_ops(20, 3, 2);
        send_op(op_div, rand_bits(32), rand_bits(32));
        present_op(pick_op(3), rand_bits(32), rand_bits(32));
        flush = 1'b1;
        step();
        flush       = 1'b0;
        issue_valid = 1'b0;
        run_ops(30, 3, 2);
        end_test("flush");

        $display("tests %0d, results checked %0d, errors %0d", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
exec_pkg.sv
issue_register.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
result_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f --top-module tb_exec_cluster
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_exec_cluster)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
